// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_png_filter
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "=== PASS ===" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
+incdir+verilog
verilog/png_filter_pkg.sv
verilog/paeth_pred.sv
verilog/filter_ctrl.sv
verilog/row_fetch.sv
verilog/residual_gen.sv
verilog/cost_select.sv
verilog/png_filter_top.sv
testbench/tb_png_filter.sv

// File: testbench/filter_trace.txt
# C width height | S row start | P pixel hex | H expected filter | R expected residual hex
# height 3, so the fourth row is a first row again
C 3 3
S
P 64646464
P 64646464
P 64646464
H 1
R 64646464
R 00000000
R 00000000
S
P 64646464
P 64646464
P 64646464
H 2
R 00000000
R 00000000
R 00000000
S
P 64646464
P 1E1E1E1E
P 1E1E1E1E
H 4
R 00000000
R BABABABA
R 00000000
S
P 14141414
P 0A0A0A0A
P 05050505
H 3
R 14141414
R 00000000
R 00000000
S
P 03030303
P 00000000
P 03030303
H 0
R 03030303
R 00000000
R 03030303

// File: testbench/tb_png_filter.sv
//------------------------------
// trace-driven testbench for the scanline filter engine
// rows, pixels and expected words come from testbench/filter_trace.txt
//------------------------------
`timescale 1ns/1ps
`include "png_filter_cfg.svh"

module tb_png_filter
  import png_filter_pkg::*;
;

  localparam int          CLK_HALF     = 20;
  localparam int          RST_CYC      = 8;
  localparam int          CYC_PER_LINE = 40;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
  localparam logic [31:0] LFSR_SEED    = 32'd82590;

  logic             clk;
  logic             rstn;
  logic [`W_WD-1:0] cfg_w_i;
  logic [`H_WD-1:0] cfg_h_i;
  logic             start_i;
  logic             pix_val_i;
  pixel_t           pix_i;
  logic             out_val_o;
  pixel_t           out_dat_o;
  logic             done_o;

  // trace contents
  int                  cfg_w;
  int                  cfg_h;
  int                  n_rows;
  int                  n_lines;
  bit                  trace_loaded;
  pixel_t              pix_q[$];
  logic [`FILT_WD-1:0] hdr_q[$];
  pixel_t              res_q[$];

  // collected output words
  pixel_t              out_q[$];
  int                  cyc_q[$];
  bit                  done_q[$];
  int                  cyc_cnt;
  logic [31:0]         lfsr_r;

  png_filter_top u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .cfg_w_i   (cfg_w_i),
    .cfg_h_i   (cfg_h_i),
    .start_i   (start_i),
    .pix_val_i (pix_val_i),
    .pix_i     (pix_i),
    .out_val_o (out_val_o),
    .out_dat_o (out_dat_o),
    .done_o    (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  //--- helpers ------------------
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // one step per bit taken
  task automatic get_bit(output logic bit_o);
    bit_o  = lfsr_r[0];
    lfsr_r = lfsr_next(lfsr_r);
  endtask

  task automatic check_header(input logic [`FILT_WD-1:0] got, input logic [`FILT_WD-1:0] exp,
                              input int row);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t ns: row %0d header filter %0d, expected %0d",
                         $time, row, got, exp));
    end
  endtask

  task automatic check_residual(input pixel_t got, input pixel_t exp, input int row,
                                input int col);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t ns: row %0d col %0d residual %08h, expected %08h",
                         $time, row, col, got.word, exp.word));
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    string       tag;
    logic [31:0] v1;
    logic [31:0] v2;
    fd = $fopen("testbench/filter_trace.txt", "r");
    if (fd == 0) begin
      stop_run("could not open the trace file testbench/filter_trace.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0) continue;
      if (line[0] == "#" || line[0] == "\n") continue;
      v1 = '0;
      v2 = '0;
      n = $sscanf(line, "%s %h %h", tag, v1, v2);
      if (tag == "C") begin
        cfg_w = v1;
        cfg_h = v2;
      end else if (tag == "S") begin
        n_rows++;
      end else if (tag == "P") begin
        pix_q.push_back(v1);
      end else if (tag == "H") begin
        hdr_q.push_back(v1[`FILT_WD-1:0]);
      end else if (tag == "R") begin
        res_q.push_back(v1);
      end else begin
        stop_run($sformatf("unknown line in the trace file: %s", line));
      end
      n_lines++;
    end
    $fclose(fd);
    if (pix_q.size() != n_rows * cfg_w || res_q.size() != n_rows * cfg_w ||
        hdr_q.size() != n_rows) begin
      stop_run("the trace file does not hold a full set of words for every row");
    end
  endtask

  //--- stimulus -----------------
  task automatic run_row(input int r);
    logic b0;
    logic b1;
    int   gap;
    @(negedge clk);
    start_i = 1'b1;
    cfg_w_i = cfg_w[`W_WD-1:0];
    cfg_h_i = cfg_h[`H_WD-1:0];
    @(negedge clk);
    start_i = 1'b0;
    for (int i = 0; i < cfg_w; i++) begin
      // two bits give 0 to 3 idle cycles
      get_bit(b0);
      get_bit(b1);
      gap = {b1, b0};
      repeat (gap) @(negedge clk);
      pix_val_i = 1'b1;
      pix_i     = pix_q[r * cfg_w + i];
      @(negedge clk);
      pix_val_i = 1'b0;
      pix_i     = '0;
    end
    // sampled on posedge, the monitor fills the queues on negedge
    while (done_q.size() == 0 || !done_q[done_q.size() - 1]) @(posedge clk);
    @(posedge clk);
  endtask

  task automatic check_row(input int r);
    pixel_t hdr;
    if (out_q.size() != cfg_w + 1) begin
      stop_run($sformatf("row %0d gave %0d output words instead of one header and %0d residuals",
                         r, out_q.size(), cfg_w));
    end
    hdr = out_q[0];
    if (hdr.chn[`PIX_CHN-1][`CHN_WD-1:`FILT_WD] != '0 || hdr.word[23:0] != '0) begin
      stop_run($sformatf("row %0d header word %08h has bits set outside the filter number",
                         r, hdr.word));
    end
    check_header(hdr.chn[`PIX_CHN-1][`FILT_WD-1:0], hdr_q[r], r);
    for (int i = 1; i <= cfg_w; i++) begin
      if (cyc_q[i] != cyc_q[i-1] + 1) begin
        stop_run($sformatf("row %0d output words are not on consecutive cycles", r));
      end
      if (done_q[i-1]) begin
        stop_run($sformatf("row %0d done_o came before the last residual", r));
      end
      check_residual(out_q[i], res_q[r * cfg_w + i - 1], r, i - 1);
    end
    out_q.delete();
    cyc_q.delete();
    done_q.delete();
  endtask

  //--- monitor ------------------
  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  always @(negedge clk) begin
    if (rstn) begin
      if (out_val_o) begin
        out_q.push_back(out_dat_o);
        cyc_q.push_back(cyc_cnt);
        done_q.push_back(done_o);
      end else if (done_o) begin
        stop_run("done_o was high without an output word");
      end
    end
  end

  // run limit scales with the trace length
  initial begin
    wait (trace_loaded);
    repeat (RST_CYC + n_lines * CYC_PER_LINE) @(posedge clk);
    $display("timeout: the rows did not finish in time, the DUT stopped responding");
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  end

  //--- main sequence ------------
  initial begin
    rstn         = 1'b0;
    start_i      = 1'b0;
    pix_val_i    = 1'b0;
    pix_i        = '0;
    cfg_w_i      = '0;
    cfg_h_i      = '0;
    cyc_cnt      = 0;
    n_rows       = 0;
    n_lines      = 0;
    lfsr_r       = LFSR_SEED;
    trace_loaded = 1'b0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (RST_CYC) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
      check_row(r);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: verilog/cost_select.sv
//------------------------------
// per-filter cost sums over a row and the best-filter search
// the search runs CMP_CYC cycles from cmp_start, sel_done marks the last one
//------------------------------
`timescale 1ns/1ps
`include "png_filter_cfg.svh"

module cost_select
  import png_filter_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   cost_val_i,
  input  pixel_t [`FILT_NUM-1:0] res_i,
  input  logic [`W_WD-1:0]       res_col_i,
  input  logic                   cmp_start_i,
  output logic                   sel_done_o,
  output logic [`FILT_WD-1:0]    best_type_o
);

  localparam logic [`FILT_WD-1:0] CMP_LAST = `FILT_WD'(`CMP_CYC - 1);

  logic [`COST_WD-1:0] cost_w [`FILT_NUM];
  logic [`COST_WD-1:0] sum_r  [`FILT_NUM];
  logic [`COST_WD-1:0] best_sum_r;
  logic [`FILT_WD-1:0] best_type_r;
  logic [`FILT_WD-1:0] cmp_cnt_r;
  logic                cmp_busy_r;
  logic                cmp_act;
  logic                cmp_upd;
  logic                take_cand;
  logic [`FILT_WD-1:0] cand_type;
  logic [`COST_WD-1:0] cand_sum;
  logic [`FILT_WD-1:0] ref_type;
  logic [`COST_WD-1:0] ref_sum;

  // small residuals either way round cost little, 255 - r equals ~r
  function automatic logic [`CHN_WD-1:0] byte_cost(input logic [`CHN_WD-1:0] r);
    return r[`CHN_WD-1] ? ~r : r;
  endfunction

  //--- cost sums ----------------
  always_comb begin
    for (int f = 0; f < `FILT_NUM; f++) begin
      cost_w[f] = '0;
      for (int ch = 0; ch < `PIX_CHN; ch++) begin
        cost_w[f] = cost_w[f] + {{(`COST_WD-`CHN_WD){1'b0}}, byte_cost(res_i[f].chn[ch])};
      end
    end
  end

  // column 0 opens a new row
  always_ff @(posedge clk) begin
    if (cost_val_i) begin
      for (int f = 0; f < `FILT_NUM; f++) begin
        sum_r[f] <= ((res_col_i == '0) ? '0 : sum_r[f]) + cost_w[f];
      end
    end
  end

  //--- compare ------------------
  // cycle 0 weighs Sub against None, cycles 1 to 3 the rest
  // the final cycle only presents the result
  assign cmp_act   = cmp_start_i || cmp_busy_r;
  assign cmp_upd   = cmp_act && (cmp_cnt_r != CMP_LAST);
  assign cand_type = cmp_cnt_r + 1'b1;
  assign cand_sum  = (cand_type < `FILT_NUM) ? sum_r[cand_type] : '1;
  assign ref_type  = (cmp_cnt_r == '0) ? `FILT_NONE : best_type_r;
  assign ref_sum   = (cmp_cnt_r == '0) ? sum_r[`FILT_NONE] : best_sum_r;
  // strictly smaller wins, so ties keep the lower number
  assign take_cand = cand_sum < ref_sum;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cmp_busy_r  <= 1'b0;
      cmp_cnt_r   <= '0;
      best_type_r <= `FILT_NONE;
    end else if (cmp_act) begin
      cmp_busy_r <= (cmp_cnt_r != CMP_LAST);
      cmp_cnt_r  <= (cmp_cnt_r == CMP_LAST) ? '0 : cmp_cnt_r + 1'b1;
      if (cmp_upd) begin
        best_type_r <= take_cand ? cand_type : ref_type;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmp_upd) begin
      best_sum_r <= take_cand ? cand_sum : ref_sum;
    end
  end

  assign sel_done_o  = cmp_act && (cmp_cnt_r == CMP_LAST);
  assign best_type_o = best_type_r;

  a_best_range: assert property (@(posedge clk) disable iff (!rstn)
    sel_done_o |-> best_type_o < `FILT_NUM);

endmodule

// File: verilog/filter_ctrl.sv
//------------------------------
// row sequencer: idle, measure, compare, emit
// counts pixels, paces the reads and times cmp_start and done
//------------------------------
`timescale 1ns/1ps
`include "png_filter_cfg.svh"

module filter_ctrl (
  input  logic             clk,
  input  logic             rstn,
  input  logic             start_i,
  input  logic [`W_WD-1:0] cfg_w_i,
  input  logic [`H_WD-1:0] cfg_h_i,
  input  logic             pix_val_i,
  input  logic             sel_done_i,
  output logic             rd_val_o,
  output logic [`W_WD-1:0] col_o,
  output logic             fnl_o,
  output logic             first_row_o,
  output logic             cmp_start_o,
  output logic             done_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_MEAS = 2'd1;
  localparam logic [1:0] ST_CMP  = 2'd2;
  localparam logic [1:0] ST_EMIT = 2'd3;
  // last cost lands in the sums three cycles after the final pixel
  localparam logic [2:0] CMP_DLY = 3'd3;

  logic [1:0]       state_r;
  logic [1:0]       state_nxt;
  logic [`W_WD-1:0] w_r;
  logic [`H_WD-1:0] h_r;
  logic [`W_WD-1:0] col_r;
  logic [`H_WD-1:0] row_r;
  logic [2:0]       drain_r;
  logic             rd_on_r;
  logic [1:0]       done_pipe_r;
  logic             rd_meas;
  logic             rd_emit;
  logic             col_last;

  assign col_last = (col_r == w_r - 1'b1);

  // measure reads follow the pixel strobes
  // the emit burst starts with sel_done so residuals trail the header
  assign rd_meas = (state_r == ST_MEAS) && pix_val_i;
  assign rd_emit = ((state_r == ST_CMP) && sel_done_i) || ((state_r == ST_EMIT) && rd_on_r);

  assign rd_val_o    = rd_meas || rd_emit;
  assign col_o       = col_r;
  assign fnl_o       = (state_r == ST_CMP) || (state_r == ST_EMIT);
  assign first_row_o = (row_r == '0);
  assign cmp_start_o = (state_r == ST_CMP) && (drain_r == CMP_DLY);
  assign done_o      = done_pipe_r[1];

  //--- phase machine ------------
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE: if (start_i) state_nxt = ST_MEAS;
      ST_MEAS: if (rd_meas && col_last) state_nxt = ST_CMP;
      ST_CMP:  if (sel_done_i) state_nxt = ST_EMIT;
      default: if (done_pipe_r[1]) state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r     <= ST_IDLE;
      w_r         <= '0;
      h_r         <= '0;
      col_r       <= '0;
      row_r       <= '0;
      drain_r     <= '0;
      rd_on_r     <= 1'b0;
      done_pipe_r <= '0;
    end else begin
      state_r <= state_nxt;
      if ((state_r == ST_IDLE) && start_i) begin
        w_r <= cfg_w_i;
        h_r <= cfg_h_i;
      end
      // column wraps after the last pixel of either pass
      if (rd_val_o) begin
        col_r <= col_last ? '0 : col_r + 1'b1;
      end
      // pipeline drain before the compare, saturates past the start point
      if (state_r != ST_CMP) begin
        drain_r <= '0;
      end else if (drain_r != 3'd4) begin
        drain_r <= drain_r + 1'b1;
      end
      if (rd_emit) begin
        rd_on_r <= !col_last;
      end
      // last residual leaves two cycles after its read
      done_pipe_r <= {done_pipe_r[0], rd_emit && col_last};
      if (done_pipe_r[1]) begin
        row_r <= (row_r == h_r - 1'b1) ? '0 : row_r + 1'b1;
      end
    end
  end

  // pixels only arrive while a row is being measured
  a_no_late_pix: assert property (@(posedge clk) disable iff (!rstn)
    $rose(pix_val_i) |-> (state_r != ST_CMP) && (state_r != ST_EMIT));

endmodule

// File: verilog/paeth_pred.sv
//------------------------------
// paeth predictor for one channel, purely combinational
//------------------------------
`timescale 1ns/1ps

module paeth_pred #(
  parameter int CHN_W = 8
) (
  input  logic [CHN_W-1:0] a_i,
  input  logic [CHN_W-1:0] b_i,
  input  logic [CHN_W-1:0] c_i,
  output logic [CHN_W-1:0] p_o
);

  // two extra bits hold the sign and the carry of a + b - c
  logic signed [CHN_W+1:0] p;
  logic signed [CHN_W+1:0] da;
  logic signed [CHN_W+1:0] db;
  logic signed [CHN_W+1:0] dc;
  logic        [CHN_W+1:0] pa;
  logic        [CHN_W+1:0] pb;
  logic        [CHN_W+1:0] pc;

  assign p  = $signed({2'b00, a_i}) + $signed({2'b00, b_i}) - $signed({2'b00, c_i});
  assign da = p - $signed({2'b00, a_i});
  assign db = p - $signed({2'b00, b_i});
  assign dc = p - $signed({2'b00, c_i});
  assign pa = da[CHN_W+1] ? $unsigned(-da) : $unsigned(da);
  assign pb = db[CHN_W+1] ? $unsigned(-db) : $unsigned(db);
  assign pc = dc[CHN_W+1] ? $unsigned(-dc) : $unsigned(dc);

  // ties go to a, then b
  assign p_o = ((pa <= pb) && (pa <= pc)) ? a_i : ((pb <= pc) ? b_i : c_i);

endmodule

// File: verilog/png_filter_cfg.svh
//------------------------------
// widths, sizes and filter codes of the scanline filter engine
// pulled in with `include by every file that needs them
//------------------------------
`ifndef PNG_FILTER_CFG_SVH
`define PNG_FILTER_CFG_SVH

// pixel layout
`define CHN_WD      8
`define PIX_CHN     4
`define PIX_WD      32

// row geometry
`define MAX_W       16
`define W_WD        5
`define H_WD        8

// filter numbering as written into the header byte
`define FILT_WD     3
`define FILT_NUM    5
`define FILT_NONE   3'd0
`define FILT_SUB    3'd1
`define FILT_UP     3'd2
`define FILT_AVG    3'd3
`define FILT_PAETH  3'd4

// cost sums and best-filter search
`define COST_WD     16
`define CMP_CYC     5

`endif

// File: verilog/png_filter_pkg.sv
//------------------------------
// types shared by the filter engine
// modules take them with a wildcard import
//------------------------------
`include "png_filter_cfg.svh"

package png_filter_pkg;

  // one pixel word
  // flat view for storage and ports, channel view for the arithmetic
  // channel 0 sits in the low byte
  typedef union packed {
    logic [`PIX_WD-1:0]               word;
    logic [`PIX_CHN-1:0][`CHN_WD-1:0] chn;
  } pixel_t;

endpackage

// File: verilog/png_filter_top.sv
//------------------------------
// scanline filter engine top level
// one start per row, then W pixel strobes, then header and W residuals
//------------------------------
`timescale 1ns/1ps
`include "png_filter_cfg.svh"

module png_filter_top
  import png_filter_pkg::*;
(
  input  logic             clk,
  input  logic             rstn,
  input  logic [`W_WD-1:0] cfg_w_i,
  input  logic [`H_WD-1:0] cfg_h_i,
  input  logic             start_i,
  input  logic             pix_val_i,
  input  pixel_t           pix_i,
  output logic             out_val_o,
  output pixel_t           out_dat_o,
  output logic             done_o
);

  // ctrl to fetch
  logic                   rd_val;
  logic [`W_WD-1:0]       col;
  logic                   fnl;
  logic                   first_row;
  // fetch to residuals
  logic                   x_val;
  pixel_t                 x;
  pixel_t                 b;
  logic [`W_WD-1:0]       x_col;
  logic                   x_fnl;
  // residuals to cost
  logic                   cost_val;
  pixel_t [`FILT_NUM-1:0] res;
  logic [`W_WD-1:0]       res_col;
  // compare handshake
  logic                   cmp_start;
  logic                   sel_done;
  logic [`FILT_WD-1:0]    best_type;

  filter_ctrl u_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .cfg_w_i     (cfg_w_i),
    .cfg_h_i     (cfg_h_i),
    .pix_val_i   (pix_val_i),
    .sel_done_i  (sel_done),
    .rd_val_o    (rd_val),
    .col_o       (col),
    .fnl_o       (fnl),
    .first_row_o (first_row),
    .cmp_start_o (cmp_start),
    .done_o      (done_o)
  );

  row_fetch u_fetch (
    .clk         (clk),
    .rstn        (rstn),
    .rd_val_i    (rd_val),
    .col_i       (col),
    .fnl_i       (fnl),
    .first_row_i (first_row),
    .pix_i       (pix_i),
    .x_val_o     (x_val),
    .x_o         (x),
    .b_o         (b),
    .x_col_o     (x_col),
    .x_fnl_o     (x_fnl)
  );

  residual_gen u_res (
    .clk         (clk),
    .rstn        (rstn),
    .x_val_i     (x_val),
    .x_i         (x),
    .b_i         (b),
    .x_col_i     (x_col),
    .x_fnl_i     (x_fnl),
    .sel_done_i  (sel_done),
    .best_type_i (best_type),
    .cost_val_o  (cost_val),
    .res_o       (res),
    .res_col_o   (res_col),
    .out_val_o   (out_val_o),
    .out_dat_o   (out_dat_o)
  );

  cost_select u_cost (
    .clk         (clk),
    .rstn        (rstn),
    .cost_val_i  (cost_val),
    .res_i       (res),
    .res_col_i   (res_col),
    .cmp_start_i (cmp_start),
    .sel_done_o  (sel_done),
    .best_type_o (best_type)
  );

endmodule

// File: verilog/residual_gen.sv
//------------------------------
// neighbour tracking and the five filter residuals
// measure items feed the cost sums, emit items and the header leave the engine
//------------------------------
`timescale 1ns/1ps
`include "png_filter_cfg.svh"

module residual_gen
  import png_filter_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   x_val_i,
  input  pixel_t                 x_i,
  input  pixel_t                 b_i,
  input  logic [`W_WD-1:0]       x_col_i,
  input  logic                   x_fnl_i,
  input  logic                   sel_done_i,
  input  logic [`FILT_WD-1:0]    best_type_i,
  output logic                   cost_val_o,
  output pixel_t [`FILT_NUM-1:0] res_o,
  output logic [`W_WD-1:0]       res_col_o,
  output logic                   out_val_o,
  output pixel_t                 out_dat_o
);

  //  c b
  //  a x
  pixel_t                 a_r;
  pixel_t                 c_r;
  pixel_t                 a_w;
  pixel_t                 c_w;
  pixel_t                 p_w;
  pixel_t                 hdr_w;
  pixel_t [`FILT_NUM-1:0] res_w;

  // previous item becomes the left and corner neighbour
  always_ff @(posedge clk) begin
    if (x_val_i) begin
      a_r <= x_i;
      c_r <= b_i;
    end
  end

  // nothing to the left of column 0
  assign a_w = (x_col_i == '0) ? '0 : a_r;
  assign c_w = (x_col_i == '0) ? '0 : c_r;

  //--- predictors ---------------
  for (genvar gi = 0; gi < `PIX_CHN; gi++) begin : g_chn
    logic [`CHN_WD:0] avg_sum;

    assign avg_sum = a_w.chn[gi] + b_i.chn[gi];

    paeth_pred #(
      .CHN_W (`CHN_WD)
    ) u_paeth (
      .a_i (a_w.chn[gi]),
      .b_i (b_i.chn[gi]),
      .c_i (c_w.chn[gi]),
      .p_o (p_w.chn[gi])
    );

    // all differences wrap modulo 256
    assign res_w[`FILT_NONE].chn[gi]  = x_i.chn[gi];
    assign res_w[`FILT_SUB].chn[gi]   = x_i.chn[gi] - a_w.chn[gi];
    assign res_w[`FILT_UP].chn[gi]    = x_i.chn[gi] - b_i.chn[gi];
    assign res_w[`FILT_AVG].chn[gi]   = x_i.chn[gi] - avg_sum[`CHN_WD:1];
    assign res_w[`FILT_PAETH].chn[gi] = x_i.chn[gi] - p_w.chn[gi];
  end

  // header carries the filter number in the top byte
  always_comb begin
    hdr_w = '0;
    hdr_w.chn[`PIX_CHN-1] = {{(`CHN_WD-`FILT_WD){1'b0}}, best_type_i};
  end

  //--- output stage -------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cost_val_o <= 1'b0;
      out_val_o  <= 1'b0;
    end else begin
      cost_val_o <= x_val_i && !x_fnl_i;
      out_val_o  <= sel_done_i || (x_val_i && x_fnl_i);
    end
  end

  always_ff @(posedge clk) begin
    if (x_val_i) begin
      res_o     <= res_w;
      res_col_o <= x_col_i;
    end
    if (sel_done_i) begin
      out_dat_o <= hdr_w;
    end else if (x_val_i && x_fnl_i) begin
      out_dat_o <= res_w[best_type_i];
    end
  end

endmodule

// File: verilog/row_fetch.sv
//------------------------------
// current-row and previous-row stores
// returns each pixel x together with its upper neighbour b
//------------------------------
`timescale 1ns/1ps
`include "png_filter_cfg.svh"

module row_fetch
  import png_filter_pkg::*;
(
  input  logic             clk,
  input  logic             rstn,
  input  logic             rd_val_i,
  input  logic [`W_WD-1:0] col_i,
  input  logic             fnl_i,
  input  logic             first_row_i,
  input  pixel_t           pix_i,
  output logic             x_val_o,
  output pixel_t           x_o,
  output pixel_t           b_o,
  output logic [`W_WD-1:0] x_col_o,
  output logic             x_fnl_o
);

  localparam int ADDR_WD = $clog2(`MAX_W);

  pixel_t             cur_mem  [`MAX_W];
  pixel_t             prev_mem [`MAX_W];
  logic [ADDR_WD-1:0] addr;

  assign addr = col_i[ADDR_WD-1:0];

  // measure fills the current row
  // emit copies it into the previous row behind the read
  always_ff @(posedge clk) begin
    if (rd_val_i) begin
      if (!fnl_i) begin
        cur_mem[addr] <= pix_i;
      end else begin
        prev_mem[addr] <= cur_mem[addr];
      end
    end
  end

  // x comes straight from the input while measuring
  always_ff @(posedge clk) begin
    if (rd_val_i) begin
      x_o <= fnl_i ? cur_mem[addr] : pix_i;
      b_o <= first_row_i ? '0 : prev_mem[addr];
    end
  end

  // item tag travels with the data
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      x_val_o <= 1'b0;
      x_col_o <= '0;
      x_fnl_o <= 1'b0;
    end else begin
      x_val_o <= rd_val_i;
      if (rd_val_i) begin
        x_col_o <= col_i;
        x_fnl_o <= fnl_i;
      end
    end
  end

  a_col_range: assert property (@(posedge clk) disable iff (!rstn)
    rd_val_i |-> col_i < `MAX_W);

endmodule
